// ==== source/frontEndCfgPkg.sv ====
package frontEndCfgPkg;

  // Decode hands over at most this many slots per cycle.
  localparam int FETCH_WIDTH = 8;

  // Dispatch always takes a full group of this size.
  localparam int DISPATCH_WIDTH = 4;

  // Circular queue depth.
  localparam int INST_QUEUE = 32;

  // Pointer width. Count register is one bit wider.
  localparam int INST_QUEUE_LOG = 5;

  // Above this occupancy a full fetch bundle might not fit.
  localparam int STALL_THRESHOLD = INST_QUEUE - FETCH_WIDTH;

  // Enough for 0..DISPATCH_WIDTH branches.
  localparam int BRANCH_COUNT_W = 3;

endpackage

// ==== source/decodedInstPkg.sv ====
package decodedInstPkg;

  // One decoded instruction as it sits in the queue.
  typedef struct packed {
    logic [31:0] pc;          // Fetch address.
    logic [7:0]  opcode;
    logic [4:0]  destReg;     // Architectural destination.
    logic [4:0]  srcReg0;
    logic [4:0]  srcReg1;
    logic [15:0] immediate;
    logic [1:0]  ldstType;    // Load/store size class.
    logic        isBranch;    // Counted at the dispatch window.
  } decodedInst_t;

  // What decode offers each cycle.
  typedef struct packed {
    logic                                                   decodeReady;
    logic         [frontEndCfgPkg::FETCH_WIDTH-1:0]         valid;
    decodedInst_t [frontEndCfgPkg::FETCH_WIDTH-1:0]         slot;
  } fetchBundle_t;

  // Group of instructions leaving toward dispatch.
  typedef struct packed {
    logic                                                   valid;
    decodedInst_t [frontEndCfgPkg::DISPATCH_WIDTH-1:0]      inst;
    logic         [frontEndCfgPkg::BRANCH_COUNT_W-1:0]      branchCount;
  } dispatchBundle_t;

endpackage

// ==== source/instQueueRam.sv ====
`timescale 1ns/1ps

// Entry storage for the queue.
// Eight write ports, one per fetch slot, and four combinational read ports.
// Write addresses are kept distinct by the control block.
module instQueueRam (
  input  logic clk,
  input  logic [frontEndCfgPkg::FETCH_WIDTH-1:0] writeEn_i,
  input  logic [frontEndCfgPkg::FETCH_WIDTH-1:0]
               [frontEndCfgPkg::INST_QUEUE_LOG-1:0] writeAddr_i,
  input  decodedInstPkg::decodedInst_t [frontEndCfgPkg::FETCH_WIDTH-1:0] writeData_i,
  input  logic [frontEndCfgPkg::DISPATCH_WIDTH-1:0]
               [frontEndCfgPkg::INST_QUEUE_LOG-1:0] readAddr_i,
  output decodedInstPkg::decodedInst_t [frontEndCfgPkg::DISPATCH_WIDTH-1:0] readData_o
);
  import frontEndCfgPkg::*;
  import decodedInstPkg::*;

  // Queue entries.
  decodedInst_t entries [INST_QUEUE];

  // Write side.
  // All enabled ports store at the same edge.
  // Packed slots land on consecutive entries, so no two ports collide.
  always_ff @(posedge clk) begin
    for (int w = 0; w < FETCH_WIDTH; w++) begin
      if (writeEn_i[w]) begin
        entries[writeAddr_i[w]] <= writeData_i[w];  // Port w.
      end
    end
  end

  // Read side.
  // Head and the three entries after it, no register in the path.
  always_comb begin
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      readData_o[r] = entries[readAddr_i[r]];  // Wraps with the pointer width.
    end
  end

endmodule

// ==== source/instQueueCtrl.sv ====
`timescale 1ns/1ps

// Pointer and occupancy control for the instruction queue.
// Packs accepted fetch slots behind the tail and retires four at the head.
module instQueueCtrl (
  input  logic clk,
  input  logic rst_i,
  input  logic flush_i,                                        // Misprediction flush.
  input  logic stall_i,                                        // Back-pressure from rename.
  input  logic decodeReady_i,
  input  logic [frontEndCfgPkg::FETCH_WIDTH-1:0] validVec_i,
  output logic [frontEndCfgPkg::FETCH_WIDTH-1:0] writeEn_o,
  output logic [frontEndCfgPkg::FETCH_WIDTH-1:0]
               [frontEndCfgPkg::INST_QUEUE_LOG-1:0] writeAddr_o,
  output logic [frontEndCfgPkg::DISPATCH_WIDTH-1:0]
               [frontEndCfgPkg::INST_QUEUE_LOG-1:0] readAddr_o,
  output logic ready_o,
  output logic stallFetch_o
);
  import frontEndCfgPkg::*;

  logic [INST_QUEUE_LOG-1:0] headPtr;       // Oldest entry.
  logic [INST_QUEUE_LOG-1:0] tailPtr;       // Next free entry.
  logic [INST_QUEUE_LOG:0]   instCount;     // Waiting instructions, 0..32.
  logic [INST_QUEUE_LOG:0]   arrivals;      // Slots accepted this cycle.
  logic [INST_QUEUE_LOG:0]   departures;    // 0 or DISPATCH_WIDTH.
  logic                      acceptBundle;
  logic                      dispatchFire;

  // Not enough room left for a full bundle.
  assign stallFetch_o = instCount > (INST_QUEUE_LOG + 1)'(STALL_THRESHOLD);

  // Whole bundle is taken or dropped.
  assign acceptBundle = decodeReady_i & ~stallFetch_o;

  // At least one full dispatch group waits.
  assign ready_o      = instCount >= (INST_QUEUE_LOG + 1)'(DISPATCH_WIDTH);
  assign dispatchFire = ready_o & ~stall_i;
  assign departures   = dispatchFire ? (INST_QUEUE_LOG + 1)'(DISPATCH_WIDTH) : '0;

  // Slot s goes to tail plus the number of accepted slots below it.
  always_comb begin : packSlots
    logic [INST_QUEUE_LOG:0] offset;
    logic                    takeSlot;
    offset = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      takeSlot       = acceptBundle & validVec_i[s];
      writeEn_o[s]   = takeSlot;
      writeAddr_o[s] = tailPtr + offset[INST_QUEUE_LOG-1:0];
      offset         = offset + (INST_QUEUE_LOG + 1)'(takeSlot);  // Running popcount.
    end
    arrivals = offset;
  end

  // Read window is always the head group.
  always_comb begin
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      readAddr_o[r] = headPtr + INST_QUEUE_LOG'(r);
    end
  end

  // Flush wins over any write in the same cycle.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr   <= tailPtr + arrivals[INST_QUEUE_LOG-1:0];  // Up to eight.
      instCount <= instCount + arrivals - departures;       // In and out together.
      if (dispatchFire) begin
        headPtr <= headPtr + INST_QUEUE_LOG'(DISPATCH_WIDTH);
      end
    end
  end

endmodule

// ==== source/dispatchWindow.sv ====
`timescale 1ns/1ps

// Forms the dispatch bundle from the head entries.
// Purely combinational.
module dispatchWindow (
  input  logic                                                              ready_i,
  input  decodedInstPkg::decodedInst_t [frontEndCfgPkg::DISPATCH_WIDTH-1:0] headInsts_i,
  output decodedInstPkg::dispatchBundle_t                                   dispatch_o
);
  import frontEndCfgPkg::*;

  logic [BRANCH_COUNT_W-1:0] branchCount;

  // Branches among the four head instructions.
  // Rename needs this to reserve checkpoints.
  always_comb begin : countBranches
    branchCount = '0;
    for (int k = 0; k < DISPATCH_WIDTH; k++) begin
      branchCount = branchCount + BRANCH_COUNT_W'(headInsts_i[k].isBranch);
    end
  end

  assign dispatch_o.valid       = ready_i;       // Only full groups leave.
  assign dispatch_o.inst        = headInsts_i;   // Oldest in lane 0.
  assign dispatch_o.branchCount = branchCount;

endmodule

// ==== source/instructionBuffer.sv ====
`timescale 1ns/1ps

// Decode to dispatch decoupling queue.
// Storage and pointer control run side by side; the window merges their outputs.
module instructionBuffer (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            flush_i,
  input  logic                            stall_i,
  input  decodedInstPkg::fetchBundle_t    fetch_i,
  output logic                            stallFetch_o,
  output decodedInstPkg::dispatchBundle_t dispatch_o
);
  import frontEndCfgPkg::*;
  import decodedInstPkg::*;

  logic [FETCH_WIDTH-1:0]                         writeEn;
  logic [FETCH_WIDTH-1:0][INST_QUEUE_LOG-1:0]     writeAddr;
  logic [DISPATCH_WIDTH-1:0][INST_QUEUE_LOG-1:0]  readAddr;
  decodedInst_t [DISPATCH_WIDTH-1:0]              headInsts;
  logic                                           ready;

  instQueueRam queueRam (
    .clk         (clk),
    .writeEn_i   (writeEn),
    .writeAddr_i (writeAddr),
    .writeData_i (fetch_i.slot),    // Slots go in unpacked; addressing does the packing.
    .readAddr_i  (readAddr),
    .readData_o  (headInsts)
  );

  instQueueCtrl queueCtrl (
    .clk           (clk),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .stall_i       (stall_i),
    .decodeReady_i (fetch_i.decodeReady),
    .validVec_i    (fetch_i.valid),
    .writeEn_o     (writeEn),
    .writeAddr_o   (writeAddr),
    .readAddr_o    (readAddr),
    .ready_o       (ready),
    .stallFetch_o  (stallFetch_o)
  );

  dispatchWindow dispWindow (
    .ready_i     (ready),
    .headInsts_i (headInsts),
    .dispatch_o  (dispatch_o)
  );

endmodule

// ==== dv/instBuffer_props.sv ====
`timescale 1ns/1ps

// Queue control properties.
// Bound into every instQueueCtrl instance.
module instBuffer_props (
  input logic                                    clk,
  input logic                                    rst_i,
  input logic                                    flush_i,
  input logic                                    stallFetch_i,
  input logic                                    ready_i,
  input logic [frontEndCfgPkg::FETCH_WIDTH-1:0]  writeEn_i,
  input logic [frontEndCfgPkg::INST_QUEUE_LOG:0] instCount_i
);
  import frontEndCfgPkg::*;

  int assertFails = 0;  // Failure tally, read from the testbench.

  // Occupancy can never pass the depth.
  countInRange: assert property (@(posedge clk) disable iff (rst_i)
    instCount_i <= (INST_QUEUE_LOG + 1)'(INST_QUEUE))
  else begin
    assertFails++;
    $error("Occupancy count above queue depth.");
  end

  // Whole bundle dropped while fetch is stalled.
  noWriteWhileStalled: assert property (@(posedge clk) disable iff (rst_i)
    stallFetch_i |-> (writeEn_i == '0))
  else begin
    assertFails++;
    $error("Write enable set while fetch is stalled.");
  end

  // Empty queue right after a flush.
  flushClearsReady: assert property (@(posedge clk) disable iff (rst_i)
    flush_i |=> !ready_i)
  else begin
    assertFails++;
    $error("Dispatch ready the cycle after a flush.");
  end

endmodule

// ==== dv/instBufferTb.sv ====
`timescale 1ns/1ps

module instBufferTb;
  import frontEndCfgPkg::*;
  import decodedInstPkg::*;

  logic            clk;
  logic            rst_i;
  logic            flush_i;
  logic            stall_i;
  fetchBundle_t    fetch_i;
  logic            stallFetch_o;
  dispatchBundle_t dispatch_o;

  decodedInst_t modelQ[$];  // Reference queue, oldest first.
  int errorCount = 0;
  int checkCount = 0;
  int testCount  = 0;
  int cycleCount = 0;

  instructionBuffer UUT (
    .clk          (clk),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .stall_i      (stall_i),
    .fetch_i      (fetch_i),
    .stallFetch_o (stallFetch_o),
    .dispatch_o   (dispatch_o)
  );

  bind instQueueCtrl instBuffer_props props (
    .clk          (clk),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .stallFetch_i (stallFetch_o),
    .ready_i      (ready_o),
    .writeEn_i    (writeEn_o),
    .instCount_i  (instCount)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period.
  end

  // Tests take a few hundred cycles. Generous margin on top.
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= 2000) begin
      $display("Timeout: run exceeded %0d cycles without finishing.", cycleCount);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic reportMismatch(input string name, input logic [511:0] expected,
                                input logic [511:0] actual);
    errorCount++;
    $display("FAIL %0t %s expected %0h got %0h", $time, name, expected, actual);
  endtask

  function automatic decodedInst_t randomInst();
    decodedInst_t inst;
    inst.pc        = $urandom;
    inst.opcode    = 8'($urandom);
    inst.destReg   = 5'($urandom);
    inst.srcReg0   = 5'($urandom);
    inst.srcReg1   = 5'($urandom);
    inst.immediate = 16'($urandom);
    inst.ldstType  = 2'($urandom);
    inst.isBranch  = 1'($urandom);  // Roughly half are branches.
    return inst;
  endfunction

  function automatic fetchBundle_t makeBundle(input logic [FETCH_WIDTH-1:0] validVec);
    fetchBundle_t bundle;
    bundle.decodeReady = 1'b1;
    bundle.valid       = validVec;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      bundle.slot[s] = randomInst();  // Invalid slots carry junk too.
    end
    return bundle;
  endfunction

  // Compares outputs with the model state after the last edge.
  task automatic checkOutputs();
    logic                      expValid;
    logic                      expStall;
    logic [BRANCH_COUNT_W-1:0] expBranch;
    expValid  = modelQ.size() >= DISPATCH_WIDTH;
    expStall  = modelQ.size() > STALL_THRESHOLD;  // No room for a full bundle.
    expBranch = '0;
    checkCount++;
    if (dispatch_o.valid !== expValid) begin
      reportMismatch("dispatch_o.valid", 512'(expValid), 512'(dispatch_o.valid));
    end
    if (stallFetch_o !== expStall) begin
      reportMismatch("stallFetch_o", 512'(expStall), 512'(stallFetch_o));
    end
    if (expValid) begin
      for (int k = 0; k < DISPATCH_WIDTH; k++) begin
        expBranch = expBranch + BRANCH_COUNT_W'(modelQ[k].isBranch);
        if (dispatch_o.inst[k] !== modelQ[k]) begin
          reportMismatch($sformatf("dispatch_o.inst[%0d]", k), 512'(modelQ[k]),
                         512'(dispatch_o.inst[k]));
        end
      end
      if (dispatch_o.branchCount !== expBranch) begin
        reportMismatch("dispatch_o.branchCount", 512'(expBranch),
                       512'(dispatch_o.branchCount));
      end
    end
  endtask

  // Predicts the next edge. Flush first, then dispatch, then packing.
  task automatic modelStep(input fetchBundle_t bundle, input logic stallIn,
                           input logic flushIn);
    logic dispatchNow;
    logic dropBundle;
    dispatchNow = (modelQ.size() >= DISPATCH_WIDTH) && !stallIn;
    dropBundle  = modelQ.size() > STALL_THRESHOLD;
    if (flushIn) begin
      modelQ.delete();  // Flush beats the write.
    end else begin
      if (dispatchNow) begin
        repeat (DISPATCH_WIDTH) void'(modelQ.pop_front());
      end
      if (bundle.decodeReady && !dropBundle) begin
        for (int s = 0; s < FETCH_WIDTH; s++) begin
          if (bundle.valid[s]) modelQ.push_back(bundle.slot[s]);  // Slot order.
        end
      end
    end
  endtask

  // Drive at the rising edge, check at the falling edge.
  task automatic runCycle(input fetchBundle_t bundle, input logic stallIn,
                          input logic flushIn);
    @(posedge clk);
    fetch_i <= bundle;
    stall_i <= stallIn;
    flush_i <= flushIn;
    @(negedge clk);
    checkOutputs();
    modelStep(bundle, stallIn, flushIn);
  endtask

  task automatic drainQueue();
    while (modelQ.size() >= DISPATCH_WIDTH) runCycle('0, 1'b0, 1'b0);
    runCycle('0, 1'b0, 1'b0);  // Let the last dispatch land.
  endtask

  task automatic finishTest(input string name, input int startErrors);
    testCount++;
    $display("%-14s %s, %0d mismatches", name,
             (errorCount == startErrors) ? "passed" : "failed", errorCount - startErrors);
  endtask

  task automatic resetTest();
    int startErrors;
    startErrors = errorCount;
    runCycle('0, 1'b0, 1'b0);
    if (dispatch_o.valid !== 1'b0) begin
      reportMismatch("dispatch_o.valid", 512'(0), 512'(dispatch_o.valid));
    end
    if (stallFetch_o !== 1'b0) begin
      reportMismatch("stallFetch_o", 512'(0), 512'(stallFetch_o));
    end
    finishTest("reset", startErrors);
  endtask

  task automatic sparsePackTest();
    int           startErrors;
    fetchBundle_t bundle;
    startErrors = errorCount;
    repeat (12) runCycle(makeBundle(8'($urandom)), 1'b0, 1'b0);
    bundle = makeBundle(8'hFF);
    bundle.decodeReady = 1'b0;  // Slots valid but decode not ready.
    runCycle(bundle, 1'b0, 1'b0);
    drainQueue();
    finishTest("sparsePacking", startErrors);
  endtask

  task automatic branchCountTest();
    int startErrors;
    startErrors = errorCount;
    repeat (10) runCycle(makeBundle(8'hFF), 1'b0, 1'b0);  // Full bundles.
    drainQueue();
    finishTest("branchCount", startErrors);
  endtask

  task automatic stallHoldTest();
    int              startErrors;
    dispatchBundle_t held;
    startErrors = errorCount;
    runCycle(makeBundle(8'hFF), 1'b1, 1'b0);
    runCycle(makeBundle(8'($urandom)), 1'b1, 1'b0);
    held       = '0;  // Head frozen from here.
    held.valid = 1'b1;
    for (int k = 0; k < DISPATCH_WIDTH; k++) begin
      held.inst[k]     = modelQ[k];
      held.branchCount = held.branchCount + BRANCH_COUNT_W'(modelQ[k].isBranch);
    end
    repeat (5) begin
      runCycle(makeBundle(8'($urandom)), 1'b1, 1'b0);
      if (dispatch_o !== held) begin
        reportMismatch("dispatch_o", 512'(held), 512'(dispatch_o));
      end
    end
    drainQueue();  // Writes during the stall must come out here.
    finishTest("stallHold", startErrors);
  endtask

  task automatic fillStallTest();
    int   startErrors;
    logic sawStall;
    startErrors = errorCount;
    sawStall    = 1'b0;
    repeat (7) begin
      runCycle(makeBundle(8'hFF), 1'b1, 1'b0);
      sawStall = sawStall | stallFetch_o;
    end
    if (!sawStall) begin
      errorCount++;
      $display("stallFetch_o never rose while the queue was filled without dispatch.");
    end
    drainQueue();  // Dropped bundles must not show up.
    finishTest("fillStall", startErrors);
  endtask

  task automatic flushTest();
    int startErrors;
    startErrors = errorCount;
    repeat (2) runCycle(makeBundle(8'hFF), 1'b1, 1'b0);
    runCycle(makeBundle(8'hFF), 1'b0, 1'b1);  // Write in the flush cycle.
    runCycle('0, 1'b0, 1'b0);
    runCycle('0, 1'b0, 1'b0);  // Flush edge has passed.
    if (dispatch_o.valid !== 1'b0) begin
      reportMismatch("dispatch_o.valid", 512'(0), 512'(dispatch_o.valid));
    end
    if (stallFetch_o !== 1'b0) begin
      reportMismatch("stallFetch_o", 512'(0), 512'(stallFetch_o));
    end
    repeat (3) runCycle(makeBundle(8'($urandom)), 1'b0, 1'b0);
    drainQueue();
    finishTest("flush", startErrors);
  endtask

  initial begin
    rst_i   = 1'b1;
    flush_i = 1'b0;
    stall_i = 1'b0;
    fetch_i = '0;
    void'($urandom(7));
    repeat (2) @(posedge clk);  // Two reset cycles.
    rst_i <= 1'b0;
    resetTest();
    sparsePackTest();
    branchCountTest();
    stallHoldTest();
    fillStallTest();
    flushTest();
    if (UUT.queueCtrl.props.assertFails != 0) begin
      $display("Queue control assertions failed %0d times.", UUT.queueCtrl.props.assertFails);
      errorCount += UUT.queueCtrl.props.assertFails;
    end
    $display("Tests: %0d, cycle checks: %0d, failures: %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/frontEndCfgPkg.sv
source/decodedInstPkg.sv
source/instQueueRam.sv
source/instQueueCtrl.sv
source/dispatchWindow.sv
source/instructionBuffer.sv
dv/instBuffer_props.sv
dv/instBufferTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the instruction buffer testbench with Verilator and run it.
verilator --binary --timing --assert --top-module instBufferTb -f sim.f -o instBufferSim \
  || exit 1
simOut=$(./obj_dir/instBufferSim)
echo "$simOut"
echo "$simOut" | grep -q "NO ERRORS" && echo "Simulation passed." \
  || { echo "Simulation failed."; exit 1; }
